//--- rv_core_pkg.sv
package rv_core_pkg;

  typedef logic [31:0] xlen_t;

  // only the opcodes this core decodes
  typedef enum logic [6:0] {
    opc_load   = 7'b000_0011,
    opc_op_imm = 7'b001_0011,
    opc_auipc  = 7'b001_0111,
    opc_store  = 7'b010_0011,
    opc_op     = 7'b011_0011,
    opc_lui    = 7'b011_0111,
    opc_jalr   = 7'b110_0111,
    opc_jal    = 7'b110_1111,
    opc_system = 7'b111_0011
  } opcode_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi; // imm[11:5]
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo; // imm[4:0]
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_fmt_t;

  // bits in instruction order: imm[20|10:1|11|19:12]
  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    opcode_e     opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

  typedef enum logic {
    src_rs1 = 1'b0,
    src_pc  = 1'b1
  } src_a_e;

  typedef enum logic [1:0] {
    wb_add  = 2'b00,
    wb_pc4  = 2'b01,
    wb_load = 2'b10
  } wb_sel_e;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_e;

endpackage

//--- rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile #(
  parameter int reg_addr_w = 5
) (
  input  logic                  clk,
  input  logic [reg_addr_w-1:0] rs1_addr,
  input  logic [reg_addr_w-1:0] rs2_addr,
  input  logic [reg_addr_w-1:0] rd_addr,
  input  logic                  rd_wen,
  input  rv_core_pkg::xlen_t    rd_data,
  output rv_core_pkg::xlen_t    rs1_data,
  output rv_core_pkg::xlen_t    rs2_data
);
  import rv_core_pkg::*;

  localparam int num_regs = 2 ** reg_addr_w;

  xlen_t regs [num_regs];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (rd_wen && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // combinational reads, x0 forced to zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  // the next read of a written register gives the new value, or zero for x0
  write_reads_back: assert property (
    @(posedge clk) rd_wen |=>
      ((rs1_addr != $past(rd_addr)) ||
       (rs1_data == (($past(rd_addr) == '0) ? '0 : $past(rd_data))))
  ) else $error("register read after a write returned a stale value");

endmodule

//--- rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder (
  input  rv_core_pkg::inst_u     inst,
  output logic [4:0]             rs1_addr,
  output logic [4:0]             rs2_addr,
  output logic [4:0]             rd_addr,
  output rv_core_pkg::xlen_t     imm,
  output rv_core_pkg::src_a_e    src_a,
  output logic                   is_reg_op,
  output rv_core_pkg::wb_sel_e   wb_sel,
  output logic                   rd_wen,
  output logic                   mem_ren,
  output logic                   mem_wen,
  output logic                   jump,
  output logic                   halt,
  output rv_core_pkg::mem_size_e mem_size,
  output logic                   mem_unsigned
);
  import rv_core_pkg::*;

  xlen_t imm_i;
  xlen_t imm_s;
  xlen_t imm_u;
  xlen_t imm_j;
  logic  is_ebreak;

  // sign always comes from inst[31]
  assign imm_i = {{20{inst.i.imm12[11]}}, inst.i.imm12};
  assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
  assign imm_u = {inst.u.imm20, 12'h000};
  assign imm_j = {{11{inst.j.imm20[19]}}, inst.j.imm20[19], inst.j.imm20[7:0],
                  inst.j.imm20[8], inst.j.imm20[18:9], 1'b0};

  // ebreak is the only system encoding honoured
  assign is_ebreak = (inst.i.imm12 == 12'h001) && (inst.i.rs1 == 5'd0) &&
                     (inst.i.funct3 == 3'b000) && (inst.i.rd == 5'd0);

  // lui reads x0 so the shared adder passes imm straight through
  assign rs1_addr = (inst.u.opcode == opc_lui) ? 5'd0 : inst.r.rs1;
  assign rs2_addr = inst.r.rs2;
  assign rd_addr  = inst.r.rd;

  assign mem_size     = mem_size_e'(inst.i.funct3[1:0]);
  assign mem_unsigned = inst.i.funct3[2]; // lbu / lhu

  always_comb begin
    imm       = '0;
    src_a     = src_rs1;
    is_reg_op = 1'b0;
    wb_sel    = wb_add;
    rd_wen    = 1'b0;
    mem_ren   = 1'b0;
    mem_wen   = 1'b0;
    jump      = 1'b0;
    halt      = 1'b0;
    case (inst.r.opcode)
      opc_op_imm: begin
        imm    = imm_i;
        rd_wen = (inst.i.funct3 == 3'b000); // addi only
      end
      opc_op: begin
        is_reg_op = 1'b1; // rs2 replaces imm on the adder
        rd_wen    = (inst.r.funct3 == 3'b000) && (inst.r.funct7 == 7'd0);
      end
      opc_lui: begin
        imm    = imm_u;
        rd_wen = 1'b1;
      end
      opc_auipc: begin
        imm    = imm_u;
        src_a  = src_pc;
        rd_wen = 1'b1;
      end
      opc_jal: begin
        imm    = imm_j;
        src_a  = src_pc;
        wb_sel = wb_pc4;
        rd_wen = 1'b1;
        jump   = 1'b1;
      end
      opc_jalr: begin
        imm    = imm_i;
        wb_sel = wb_pc4;
        rd_wen = 1'b1;
        jump   = 1'b1;
      end
      opc_load: begin
        imm    = imm_i;
        wb_sel = wb_load;
        // lb lh lw lbu lhu
        if (inst.i.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          rd_wen  = 1'b1;
          mem_ren = 1'b1;
        end
      end
      opc_store: begin
        imm     = imm_s;
        mem_wen = (inst.s.funct3 inside {3'b000, 3'b001, 3'b010});
      end
      opc_system: begin
        halt = is_ebreak;
      end
      default: begin
        // unknown, behaves as a nop
      end
    endcase
  end

  always_comb begin
    one_mem_access: assert final (!(mem_ren && mem_wen))
      else $error("load and store decoded together");
  end

endmodule

//--- rv_lsu.sv
`timescale 1ns/1ns

module rv_lsu (
  input  rv_core_pkg::xlen_t     addr,
  input  rv_core_pkg::xlen_t     store_data,
  input  rv_core_pkg::mem_size_e mem_size,
  input  logic                   mem_unsigned,
  input  logic                   mem_wen,
  input  rv_core_pkg::xlen_t     mem_rdata,
  output rv_core_pkg::xlen_t     mem_wdata,
  output logic [3:0]             mem_wmask,
  output rv_core_pkg::xlen_t     load_data
);
  import rv_core_pkg::*;

  logic [3:0] lane_mask;
  xlen_t      rdata_shifted;

  // store side, data copied to every lane so the mask alone picks the bytes
  always_comb begin
    case (mem_size)
      size_byte: begin
        mem_wdata = {4{store_data[7:0]}};
        lane_mask = 4'b0001 << addr[1:0];
      end
      size_half: begin
        mem_wdata = {2{store_data[15:0]}};
        lane_mask = addr[1] ? 4'b1100 : 4'b0011; // addr[0] ignored
      end
      default: begin
        mem_wdata = store_data;
        lane_mask = 4'b1111;
      end
    endcase
  end

  assign mem_wmask = mem_wen ? lane_mask : 4'b0000;

  // load side
  assign rdata_shifted = mem_rdata >> {addr[1:0], 3'b000};

  always_comb begin
    case (mem_size)
      size_byte: load_data = mem_unsigned ? {24'h0, rdata_shifted[7:0]} :
                                            {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
      size_half: load_data = mem_unsigned ? {16'h0, rdata_shifted[15:0]} :
                                            {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
      default:   load_data = mem_rdata;
    endcase
  end

  always_comb begin
    aligned_mask: assert final (mem_wmask inside {4'b0000, 4'b0001, 4'b0010, 4'b0100,
                                                  4'b1000, 4'b0011, 4'b1100, 4'b1111})
      else $error("write mask %b not naturally aligned", mem_wmask);
  end

endmodule

//--- rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top #(
  parameter rv_core_pkg::xlen_t reset_pc   = 32'h8000_0000,
  parameter int                 reg_addr_w = 5
) (
  input  logic               clk,
  input  logic               rst,
  output rv_core_pkg::xlen_t pc,
  input  rv_core_pkg::xlen_t inst,
  output rv_core_pkg::xlen_t mem_addr,
  output rv_core_pkg::xlen_t mem_wdata,
  output logic [3:0]         mem_wmask,
  output logic               mem_wen,
  output logic               mem_ren,
  input  rv_core_pkg::xlen_t mem_rdata,
  output logic               halt
);
  import rv_core_pkg::*;

  logic [4:0] rs1_addr;
  logic [4:0] rs2_addr;
  logic [4:0] rd_addr;
  xlen_t      imm;
  src_a_e     src_a;
  logic       is_reg_op;
  wb_sel_e    wb_sel;
  logic       dec_rd_wen;
  logic       dec_mem_ren;
  logic       dec_mem_wen;
  logic       dec_halt;
  logic       jump;
  mem_size_e  mem_size;
  logic       mem_unsigned;

  logic       rd_wen;
  xlen_t      rd_data;
  xlen_t      rs1_data;
  xlen_t      rs2_data;
  xlen_t      add_a;
  xlen_t      add_b;
  xlen_t      add_res;
  xlen_t      pc_plus4;
  xlen_t      jump_target;
  xlen_t      next_pc;
  xlen_t      load_data;

  rv_decoder decoder_i (
    .inst         (inst),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rd_addr      (rd_addr),
    .imm          (imm),
    .src_a        (src_a),
    .is_reg_op    (is_reg_op),
    .wb_sel       (wb_sel),
    .rd_wen       (dec_rd_wen),
    .mem_ren      (dec_mem_ren),
    .mem_wen      (dec_mem_wen),
    .jump         (jump),
    .halt         (dec_halt),
    .mem_size     (mem_size),
    .mem_unsigned (mem_unsigned)
  );

  // a smaller file just drops the upper address bits
  rv_regfile #(
    .reg_addr_w (reg_addr_w)
  ) regfile_i (
    .clk      (clk),
    .rs1_addr (rs1_addr[reg_addr_w-1:0]),
    .rs2_addr (rs2_addr[reg_addr_w-1:0]),
    .rd_addr  (rd_addr[reg_addr_w-1:0]),
    .rd_wen   (rd_wen),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // nothing leaves the core while in reset
  assign rd_wen  = dec_rd_wen & ~rst;
  assign mem_ren = dec_mem_ren & ~rst;
  assign mem_wen = dec_mem_wen & ~rst;
  assign halt    = dec_halt & ~rst;

  // the one adder, shared by address, alu and jump target
  assign add_a   = (src_a == src_pc) ? pc : rs1_data;
  assign add_b   = is_reg_op ? rs2_data : imm;
  assign add_res = add_a + add_b;

  assign mem_addr = add_res;

  rv_lsu lsu_i (
    .addr         (add_res),
    .store_data   (rs2_data),
    .mem_size     (mem_size),
    .mem_unsigned (mem_unsigned),
    .mem_wen      (mem_wen),
    .mem_rdata    (mem_rdata),
    .mem_wdata    (mem_wdata),
    .mem_wmask    (mem_wmask),
    .load_data    (load_data)
  );

  always_comb begin
    case (wb_sel)
      wb_pc4:  rd_data = pc_plus4; // link value
      wb_load: rd_data = load_data;
      default: rd_data = add_res;
    endcase
  end

  assign pc_plus4    = pc + 32'd4;
  assign jump_target = {add_res[31:1], 1'b0}; // jalr clears bit 0, jal is even anyway
  assign next_pc     = jump ? jump_target : pc_plus4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else if (!halt) begin
      pc <= next_pc;
    end
  end

  // once halted the core stays parked
  halt_holds_pc: assert property (
    @(posedge clk) disable iff (rst) halt |=> ($stable(pc) && !mem_wen)
  ) else $error("pc moved or memory written after halt");

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int period_ns    = 100,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // power-on reset, released on a rising edge
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core;
  import rv_core_pkg::*;

  localparam xlen_t reset_pc    = 32'h8000_0000;
  localparam int    dmem_bytes  = 4096;
  localparam xlen_t ebreak_inst = 32'h0010_0073;
  localparam xlen_t nop_inst    = 32'h0000_0013; // addi x0, x0, 0

  logic       clk;
  logic       por_rst;
  logic       test_rst = 1'b0;
  logic       rst;
  xlen_t      pc;
  xlen_t      inst;
  xlen_t      mem_addr;
  xlen_t      mem_wdata;
  xlen_t      mem_rdata;
  logic [3:0] mem_wmask;
  logic       mem_wen;
  logic       mem_ren;
  logic       halt;

  xlen_t      imem [64];
  logic [7:0] dmem [dmem_bytes];
  xlen_t      pc_off;
  logic [11:0] mem_word;
  int         prog_len;
  xlen_t      lfsr = 32'haddb_8873;
  int         errors = 0;
  int         checks = 0;
  int         cycle_count = 0;
  int         cycle_budget = 20; // covers the power-on reset
  xlen_t      pc_trace [$];
  int         exp_idx [$];
  logic [3:0] store_mask [$];
  xlen_t      load_addr [$];

  tb_clock_gen clock_i (
    .clk (clk),
    .rst (por_rst)
  );

  assign rst = por_rst | test_rst;

  rv_core_top #(
    .reset_pc   (reset_pc),
    .reg_addr_w (5)
  ) dut_i (
    .clk       (clk),
    .rst       (rst),
    .pc        (pc),
    .inst      (inst),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_wen   (mem_wen),
    .mem_ren   (mem_ren),
    .mem_rdata (mem_rdata),
    .halt      (halt)
  );

  // instruction memory, answers in the same cycle
  assign pc_off = (pc - reset_pc) >> 2;
  assign inst   = imem[pc_off[5:0]];

  // data memory, little endian bytes
  assign mem_word  = {mem_addr[11:2], 2'b00};
  assign mem_rdata = {dmem[mem_word + 3], dmem[mem_word + 2], dmem[mem_word + 1], dmem[mem_word]};

  always @(posedge clk) begin
    if (mem_wen && (mem_addr < dmem_bytes)) begin
      for (int k = 0; k < 4; k++) begin
        if (mem_wmask[k]) dmem[mem_word + k] <= mem_wdata[8*k +: 8];
      end
    end
  end

  always @(negedge clk) begin
    if (!rst && (mem_wen || mem_ren) && (mem_addr >= dmem_bytes)) begin
      errors++;
      $display("data access at %h lies outside the data memory", mem_addr);
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_budget) begin
      $display("core never halted within %0d cycles", cycle_budget);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic lfsr_step();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // x^32 + x^22 + x^2 + x + 1
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic xlen_t rand_bits(int n);
    xlen_t v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step()};
    return v;
  endfunction

  function automatic xlen_t sext12(xlen_t v);
    logic signed [11:0] s;
    s = v[11:0];
    return s;
  endfunction

  // RV32I encodings
  function automatic xlen_t enc_i(xlen_t imm, logic [4:0] rs1, logic [2:0] f3, logic [4:0] rd,
                                  opcode_e opc);
    return {imm[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic xlen_t enc_s(xlen_t imm, logic [4:0] rs2, logic [4:0] rs1, logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
  endfunction

  function automatic xlen_t enc_u(xlen_t imm20, logic [4:0] rd, opcode_e opc);
    return {imm20[19:0], rd, opc};
  endfunction

  function automatic xlen_t enc_add(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return {7'd0, rs2, rs1, 3'b000, rd, opc_op};
  endfunction

  function automatic xlen_t enc_jal(xlen_t off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
  endfunction

  function automatic logic [7:0] fill_byte(xlen_t a);
    return a[7:0] ^ {a[11:8], a[11:8]}; // every address bit matters
  endfunction

  function automatic xlen_t fill_word(xlen_t a);
    return {fill_byte(a + 3), fill_byte(a + 2), fill_byte(a + 1), fill_byte(a)};
  endfunction

  function automatic xlen_t read_word(xlen_t a);
    return {dmem[a + 3], dmem[a + 2], dmem[a + 1], dmem[a]};
  endfunction

  // RV32I load rules, f3 picks the width and the extension
  function automatic xlen_t expect_load(xlen_t w, int f3, int off);
    xlen_t lane;
    logic signed [7:0]  sb;
    logic signed [15:0] sh;
    xlen_t r;
    lane = w >> (8 * off);
    case (f3)
      0: begin
        sb = lane[7:0];
        r  = sb;
      end
      1: begin
        sh = lane[15:0];
        r  = sh;
      end
      4: r = lane[7:0];
      5: r = lane[15:0];
      default: r = w;
    endcase
    return r;
  endfunction

  task automatic check_word(string name, xlen_t exp, xlen_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_mask(string name, logic [3:0] exp, logic [3:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic emit(xlen_t word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic load_const(logic [4:0] rd, xlen_t v);
    xlen_t upper;
    upper = (v + 32'h800) >> 12; // addi sign-extends the low part
    emit(enc_u(upper, rd, opc_lui));
    emit(enc_i(v, rd, 3'b000, rd, opc_op_imm));
  endtask

  task automatic expect_seq(int n);
    for (int i = 0; i < n; i++) exp_idx.push_back(i);
  endtask

  // holds the core in reset while a new program and memory image go in
  task automatic reset_dut();
    @(posedge clk);
    test_rst <= 1'b1;
    @(negedge clk);
    prog_len = 0;
    exp_idx.delete();
    for (int i = 0; i < 64; i++) imem[i] = nop_inst;
    for (int a = 0; a < dmem_bytes; a++) dmem[a] = fill_byte(a);
  endtask

  task automatic run_program(string name);
    xlen_t halt_pc;
    cycle_budget += 20 * prog_len;
    @(posedge clk);
    @(negedge clk);
    check_word({name, " pc in reset"}, reset_pc, pc);
    check_bit({name, " mem_wen in reset"}, 1'b0, mem_wen);
    check_bit({name, " mem_ren in reset"}, 1'b0, mem_ren);
    check_bit({name, " halt in reset"}, 1'b0, halt);
    @(posedge clk);
    test_rst <= 1'b0;
    pc_trace.delete();
    store_mask.delete();
    load_addr.delete();
    do begin
      @(negedge clk);
      pc_trace.push_back(pc);
      if (mem_wen) store_mask.push_back(mem_wmask);
      if (mem_ren) load_addr.push_back(mem_addr);
    end while (!halt);
    halt_pc = pc;
    repeat (3) begin
      @(negedge clk);
      check_word({name, " pc held on halt"}, halt_pc, pc);
      check_bit({name, " store after halt"}, 1'b0, mem_wen);
    end
    check_word({name, " trace length"}, exp_idx.size(), pc_trace.size());
    for (int i = 0; i < exp_idx.size() && i < pc_trace.size(); i++) begin
      check_word({name, " pc trace"}, reset_pc + 4 * exp_idx[i], pc_trace[i]);
    end
  endtask

  task automatic test_reset();
    reset_dut();
    emit(enc_s(32'h104, 0, 0, 3'b010)); // presented while the core is held in reset
    emit(enc_i(5, 0, 3'b000, 1, opc_op_imm));
    emit(enc_i(3, 1, 3'b000, 2, opc_op_imm));
    emit(enc_s(32'h100, 2, 0, 3'b010));
    emit(ebreak_inst);
    expect_seq(5);
    run_program("reset");
    check_word("reset first store", 32'h0, read_word(32'h104));
    check_word("reset sum", 32'd8, read_word(32'h100));
  endtask

  task automatic test_arith();
    xlen_t cu;
    xlen_t ci;
    xlen_t ci2;
    xlen_t cua;
    xlen_t x1;
    xlen_t x2;
    cu  = rand_bits(20);
    ci  = rand_bits(12);
    ci2 = rand_bits(12);
    cua = rand_bits(20);
    reset_dut();
    emit(enc_u(cu, 1, opc_lui));
    emit(enc_i(ci, 1, 3'b000, 1, opc_op_imm));
    emit(enc_i(ci2, 0, 3'b000, 2, opc_op_imm));
    emit(enc_add(3, 1, 2));
    emit(enc_u(cua, 4, opc_auipc)); // at index 4
    emit(enc_s(32'h200, 3, 0, 3'b010));
    emit(enc_s(32'h204, 4, 0, 3'b010));
    emit(enc_s(32'h208, 1, 0, 3'b010));
    emit(ebreak_inst);
    expect_seq(9);
    run_program("arith");
    x1 = (cu << 12) + sext12(ci);
    x2 = sext12(ci2);
    check_word("arith lui addi", x1, read_word(32'h208));
    check_word("arith add", x1 + x2, read_word(32'h200));
    check_word("arith auipc", reset_pc + 16 + (cua << 12), read_word(32'h204));
    check_word("arith store count", 3, store_mask.size());
    check_word("arith load count", 0, load_addr.size());
    foreach (store_mask[i]) check_mask("arith sw mask", 4'b1111, store_mask[i]);
  endtask

  task automatic test_jumps();
    reset_dut();
    emit(enc_jal(12, 1));                        // to index 3
    emit(ebreak_inst);
    emit(ebreak_inst);
    emit(enc_u(0, 5, opc_auipc));
    emit(enc_i(21, 5, 3'b000, 5, opc_op_imm));   // odd target
    emit(enc_i(0, 5, 3'b000, 6, opc_jalr));      // lands on index 8
    emit(ebreak_inst);
    emit(ebreak_inst);
    emit(enc_s(32'h300, 1, 0, 3'b010));
    emit(enc_s(32'h304, 6, 0, 3'b010));
    emit(ebreak_inst);
    exp_idx = {0, 3, 4, 5, 8, 9, 10};
    run_program("jumps");
    check_word("jal link", reset_pc + 4, read_word(32'h300));
    check_word("jalr link", reset_pc + 24, read_word(32'h304));
  endtask

  task automatic test_subword_stores();
    xlen_t v;
    xlen_t exp;
    v = rand_bits(32);
    reset_dut();
    load_const(1, v);
    for (int k = 0; k < 4; k++) emit(enc_s(32'h400 + 5 * k, 1, 0, 3'b000)); // sb
    emit(enc_s(32'h410, 1, 0, 3'b001)); // sh, low half
    emit(enc_s(32'h416, 1, 0, 3'b001)); // sh, high half
    emit(ebreak_inst);
    expect_seq(9);
    run_program("subword");
    check_word("subword store count", 6, store_mask.size());
    for (int k = 0; k < 4; k++) begin
      exp = fill_word(32'h400 + 4 * k);
      exp[8*k +: 8] = v[7:0];
      check_word("sb lane", exp, read_word(32'h400 + 4 * k));
      check_mask("sb mask", 4'b0001 << k, store_mask[k]);
    end
    exp = fill_word(32'h410);
    exp[15:0] = v[15:0];
    check_word("sh low lane", exp, read_word(32'h410));
    check_mask("sh low mask", 4'b0011, store_mask[4]);
    exp = fill_word(32'h414);
    exp[31:16] = v[15:0];
    check_word("sh high lane", exp, read_word(32'h414));
    check_mask("sh high mask", 4'b1100, store_mask[5]);
  endtask

  task automatic test_loads();
    xlen_t w;
    xlen_t exp_words [$];
    xlen_t exp_addrs [$];
    int    step;
    int    n;
    w = rand_bits(32);
    n = 0;
    reset_dut();
    {dmem[32'h503], dmem[32'h502], dmem[32'h501], dmem[32'h500]} = w;
    // f3 0 lb, 1 lh, 2 lw, 4 lbu, 5 lhu
    for (int f = 0; f < 6; f++) begin
      if (f != 3) begin
        step = (f % 4 == 0) ? 1 : ((f % 4 == 1) ? 2 : 4);
        for (int off = 0; off < 4; off += step) begin
          emit(enc_i(32'h500 + off, 0, f, 2, opc_load));
          emit(enc_s(32'h600 + 4 * n, 2, 0, 3'b010));
          exp_words.push_back(expect_load(w, f, off));
          exp_addrs.push_back(32'h500 + off);
          n++;
        end
      end
    end
    emit(ebreak_inst);
    expect_seq(prog_len);
    run_program("loads");
    foreach (exp_words[i]) check_word("load result", exp_words[i], read_word(32'h600 + 4 * i));
    check_word("load count", exp_addrs.size(), load_addr.size());
    foreach (exp_addrs[i]) begin
      if (i < load_addr.size()) check_word("load address", exp_addrs[i], load_addr[i]);
    end
  endtask

  task automatic test_x0_halt();
    reset_dut();
    emit(enc_i(123, 0, 3'b000, 0, opc_op_imm));
    emit(enc_u(32'h12345, 0, opc_lui));
    emit(enc_s(32'h700, 0, 0, 3'b010));
    emit(ebreak_inst);
    emit(enc_s(32'h704, 0, 0, 3'b010)); // never reached
    expect_seq(4);
    run_program("x0_halt");
    check_word("x0 reads zero", 32'h0, read_word(32'h700));
    check_word("no store past ebreak", fill_word(32'h704), read_word(32'h704));
    check_word("x0_halt store count", 1, store_mask.size());
  endtask

  // ebreak sits on the reset pc, so halt must stay low until reset drops
  task automatic test_halt_first();
    reset_dut();
    emit(ebreak_inst);
    emit(enc_s(32'h708, 0, 0, 3'b010)); // never reached
    expect_seq(1);
    run_program("halt_first");
    check_word("halt_first store count", 0, store_mask.size());
    check_word("halt_first memory kept", fill_word(32'h708), read_word(32'h708));
  endtask

  initial begin
    test_reset();
    test_arith();
    test_jumps();
    test_subword_stores();
    test_loads();
    test_x0_halt();
    test_halt_first();
    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- rv_core_top.f
rv_core_pkg.sv
rv_regfile.sv
rv_decoder.sv
rv_lsu.sv
rv_core_top.sv
tb_clock_gen.sv
tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - rv_core_pkg.sv
  - rv_regfile.sv
  - rv_decoder.sv
  - rv_lsu.sv
  - rv_core_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_rv_core.sv
